// ==== all.f ====
+incdir+hdl
hdl/usb_proxy_pkg.sv
hdl/pkt_decode.sv
hdl/proxy_fsm.sv
hdl/monitor_stats.sv
hdl/usb_proxy_top.sv
test/tb_usb_proxy.sv

// ==== hdl/monitor_stats.sv ====
/*
 * Monitor statistics
 * Packet, CRC error and capture drop counters, the status
 * register and the byte wide readback port
 */
`default_nettype none

`include "usb_proxy_defines.svh"

module monitor_stats (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire usb_proxy_pkg::pkt_event_t events,
    input  wire                            host_counted,
    input  wire                            dev_counted,
    input  wire                            drop,
    input  wire usb_proxy_pkg::frame_num_t frame_num,
    input  wire                            connected,
    input  wire                            proxy_enable,
    input  wire usb_proxy_pkg::byte_t      reg_addr,
    output usb_proxy_pkg::byte_t           status_register,
    output usb_proxy_pkg::byte_t           reg_read_data
);

    import usb_proxy_pkg::*;

    pkt_count_t host_pkts;
    pkt_count_t dev_pkts;
    err_count_t err_cnt;      // CRC failures on either side
    err_count_t drop_cnt;     // Capture bytes lost to back-pressure
    byte_t      status_next;

    always_comb begin
        status_next                  = '0;
        status_next[`STAT_CONNECTED] = connected;
        status_next[`STAT_ERROR]     = events.crc_err;   // One cycle pulse
        status_next[`STAT_PROXY_EN]  = proxy_enable;
        status_next[`STAT_DROP]      = status_register[`STAT_DROP] || drop;   // Sticky
    end

    ////////////////////////////////////////////////////////////
    // Counters and status
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_pkts       <= '0;
            dev_pkts        <= '0;
            err_cnt         <= '0;
            drop_cnt        <= '0;
            status_register <= '0;
        end else begin
            status_register <= status_next;
            if (host_counted)
                host_pkts <= host_pkts + 1'b1;
            if (dev_counted)
                dev_pkts <= dev_pkts + 1'b1;
            if (events.crc_err)
                err_cnt <= err_cnt + 1'b1;
            if (drop)
                drop_cnt <= drop_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_addr)
            `REG_STATUS:         reg_read_data = status_register;
            `REG_ERR_LO:         reg_read_data = err_cnt[7:0];
            `REG_ERR_LO + 8'd1:  reg_read_data = err_cnt[15:8];
            `REG_HOST_PKT0:        reg_read_data = host_pkts[7:0];
            `REG_HOST_PKT0 + 8'd1: reg_read_data = host_pkts[15:8];
            `REG_HOST_PKT0 + 8'd2: reg_read_data = host_pkts[23:16];
            `REG_HOST_PKT0 + 8'd3: reg_read_data = host_pkts[31:24];
            `REG_DEV_PKT0:         reg_read_data = dev_pkts[7:0];
            `REG_DEV_PKT0 + 8'd1:  reg_read_data = dev_pkts[15:8];
            `REG_DEV_PKT0 + 8'd2:  reg_read_data = dev_pkts[23:16];
            `REG_DEV_PKT0 + 8'd3:  reg_read_data = dev_pkts[31:24];
            `REG_FRAME_LO:       reg_read_data = frame_num[7:0];
            `REG_FRAME_HI:       reg_read_data = frame_num[15:8];
            `REG_DROP_LO:        reg_read_data = drop_cnt[7:0];
            `REG_DROP_HI:        reg_read_data = drop_cnt[15:8];
            default:             reg_read_data = '0;   // Unmapped
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/pkt_decode.sv ====
/*
 * Packet event decoder
 * Turns the raw receive strobes of the host and device sides
 * into start, end, SOF and CRC error events. Purely
 * combinational
 */
`default_nettype none

`include "usb_proxy_defines.svh"

module pkt_decode (
    input  wire usb_proxy_pkg::usb_rx_t host_rx,
    input  wire usb_proxy_pkg::usb_rx_t device_rx,
    output usb_proxy_pkg::pkt_event_t   events
);

    logic host_bad_crc;   // Host EOP with failed CRC
    logic dev_bad_crc;    // Device EOP with failed CRC

    ////////////////////////////////////////////////////////////
    // CRC checks
    ////////////////////////////////////////////////////////////

    always_comb begin
        host_bad_crc = host_rx.valid && host_rx.eop && !host_rx.crc_valid;
        dev_bad_crc  = device_rx.valid && device_rx.eop && !device_rx.crc_valid;
    end

    ////////////////////////////////////////////////////////////
    // Event bundle
    ////////////////////////////////////////////////////////////

    always_comb begin
        events = '0;

        // Packet boundaries
        events.host_start = host_rx.valid && host_rx.sop;
        events.dev_start  = device_rx.valid && device_rx.sop;
        events.host_end   = host_rx.eop;
        events.dev_end    = device_rx.eop;

        events.is_sof  = (host_rx.pid == `PID_SOF);   // Only the host sends SOF
        events.crc_err = host_bad_crc || dev_bad_crc;
    end

endmodule

`default_nettype wire

// ==== hdl/proxy_fsm.sv ====
/*
 * Proxy state machine
 * Routes host packets to the device and device packets back
 * to the host, waits a bounded time for the device response,
 * copies every forwarded byte to the capture port and picks
 * the frame number out of SOF packets
 */
`default_nettype none

`include "usb_proxy_defines.svh"

module proxy_fsm (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire usb_proxy_pkg::usb_rx_t    host_rx,
    input  wire usb_proxy_pkg::usb_rx_t    device_rx,
    input  wire usb_proxy_pkg::pkt_event_t events,
    input  wire                            proxy_enable,
    input  wire [1:0]                      device_line_state,
    input  wire usb_proxy_pkg::timestamp_t timestamp,
    input  wire                            buffer_ready,
    output usb_proxy_pkg::usb_tx_t         host_tx,
    output usb_proxy_pkg::usb_tx_t         device_tx,
    output usb_proxy_pkg::capture_t        capture,
    output logic                           capture_valid,
    output logic                           host_counted,
    output logic                           dev_counted,
    output logic                           drop,
    output usb_proxy_pkg::frame_num_t      frame_num,
    output logic                           connected
);

    import usb_proxy_pkg::*;

    localparam int WAIT_W = $clog2(`RESP_TIMEOUT + 1);

    proxy_state_e      state;
    proxy_state_e      next_state;
    pid_t              cur_pid;     // PID of the packet in flight
    pid_t              byte_pid;
    timestamp_t        sop_ts;
    logic [WAIT_W-1:0] wait_cnt;
    logic [1:0]        sof_idx;     // Byte index inside SOF, saturates at 3
    logic              host_accept;
    logic              dev_accept;
    logic              host_route;
    logic              dev_route;
    logic              fwd_valid;

    ////////////////////////////////////////////////////////////
    // Start acceptance and routing
    ////////////////////////////////////////////////////////////

    assign host_accept = (state == ST_IDLE) && proxy_enable && events.host_start;
    assign dev_accept  = proxy_enable && events.dev_start &&
                         ((state == ST_WAIT_DEV_RESP) ||
                          ((state == ST_IDLE) && !events.host_start));   // Host wins a tie

    // SOF is consumed here, never forwarded
    assign host_route = (state == ST_HOST_TO_DEV) || (host_accept && !events.is_sof);
    assign dev_route  = (state == ST_DEV_TO_HOST) || dev_accept;
    assign fwd_valid  = (host_route && host_rx.valid) || (dev_route && device_rx.valid);

    assign host_counted = host_accept;
    assign dev_counted  = dev_accept;
    assign drop         = fwd_valid && !buffer_ready;

    // The SOP byte carries its PID before cur_pid is loaded
    assign byte_pid = host_accept ? host_rx.pid : (dev_accept ? device_rx.pid : cur_pid);

    always_comb begin
        host_tx   = '0;
        device_tx = '0;
        if (host_route) begin
            device_tx = '{data: host_rx.data, valid: host_rx.valid, sop: host_rx.sop,
                          eop: host_rx.eop, pid: host_rx.pid};
        end
        if (dev_route) begin
            host_tx = '{data: device_rx.data, valid: device_rx.valid, sop: device_rx.sop,
                        eop: device_rx.eop, pid: device_rx.pid};
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (host_accept && events.is_sof)
                    next_state = events.host_end ? ST_IDLE : ST_SOF;
                else if (host_accept)
                    next_state = events.host_end ? ST_WAIT_DEV_RESP : ST_HOST_TO_DEV;
                else if (dev_accept)
                    next_state = events.dev_end ? ST_IDLE : ST_DEV_TO_HOST;
            end
            ST_HOST_TO_DEV:   if (events.host_end) next_state = ST_WAIT_DEV_RESP;
            ST_WAIT_DEV_RESP: begin
                if (dev_accept)
                    next_state = events.dev_end ? ST_IDLE : ST_DEV_TO_HOST;
                else if (wait_cnt == WAIT_W'(`RESP_TIMEOUT - 1))
                    next_state = ST_IDLE;   // No response in time
            end
            ST_DEV_TO_HOST:   if (events.dev_end) next_state = ST_IDLE;
            ST_SOF:           if (events.host_end) next_state = ST_IDLE;
            default:          next_state = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            wait_cnt      <= '0;
            sof_idx       <= '0;
            frame_num     <= '0;
            connected     <= 1'b0;
            capture_valid <= 1'b0;
        end else begin
            state         <= next_state;
            capture_valid <= fwd_valid && buffer_ready;
            wait_cnt      <= (state == ST_WAIT_DEV_RESP) ? wait_cnt + 1'b1 : '0;
            if (state == ST_IDLE)
                connected <= (device_line_state != 2'b00);

            if (host_accept && events.is_sof) begin
                sof_idx <= 2'd1;   // SOP byte is index 0
            end else if ((state == ST_SOF) && host_rx.valid) begin
                if (sof_idx == 2'd1)
                    frame_num[`USB_BYTE_W-1:0] <= host_rx.data;
                if (sof_idx == 2'd2)
                    frame_num[2*`USB_BYTE_W-1:`USB_BYTE_W] <= host_rx.data;
                if (sof_idx != 2'd3)
                    sof_idx <= sof_idx + 2'd1;
            end
        end
    end

    // Packet context and capture payload
    always_ff @(posedge clk) begin
        if (host_accept || dev_accept) begin
            cur_pid <= byte_pid;
            sop_ts  <= timestamp;
        end
        if (fwd_valid && buffer_ready) begin
            capture.data      <= host_route ? host_rx.data : device_rx.data;
            capture.flags     <= {byte_pid, {(`USB_BYTE_W - `USB_PID_W - 1){1'b0}}, dev_route};
            capture.timestamp <= (host_accept || dev_accept) ? timestamp : sop_ts;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/usb_proxy_defines.svh ====
/*
 * USB proxy shared constants
 * Data widths, PID codes, status bit positions, readback
 * register map and the device response timeout
 */
`ifndef USB_PROXY_DEFINES_SVH
`define USB_PROXY_DEFINES_SVH

// Widths
`define USB_BYTE_W      8
`define USB_PID_W       4
`define TIMESTAMP_W     64
`define PKT_COUNT_W     32
`define ERR_COUNT_W     16

`define RESP_TIMEOUT    200     // Cycles to wait for a device response

// PID codes
`define PID_OUT         4'b0001
`define PID_IN          4'b1001
`define PID_SETUP       4'b1101
`define PID_ACK         4'b0010
`define PID_SOF         4'b0101

// Status register bits
`define STAT_CONNECTED  0
`define STAT_ERROR      1
`define STAT_PROXY_EN   2
`define STAT_DROP       3

// Readback addresses
`define REG_STATUS      8'h00
`define REG_ERR_LO      8'h01   // High byte follows
`define REG_HOST_PKT0   8'h03   // Four bytes, LSB first
`define REG_DEV_PKT0    8'h07   // Four bytes, LSB first
`define REG_FRAME_LO    8'h0B
`define REG_FRAME_HI    8'h0C
`define REG_DROP_LO     8'h0D
`define REG_DROP_HI     8'h0E

`endif

// ==== hdl/usb_proxy_pkg.sv ====
/*
 * USB proxy types
 * Vector types for the widths used across the proxy, the
 * receive, transmit, event and capture bundles, and the
 * proxy state encoding
 */
`default_nettype none

`include "usb_proxy_defines.svh"

package usb_proxy_pkg;

    typedef logic [`USB_BYTE_W-1:0]   byte_t;
    typedef logic [`USB_PID_W-1:0]    pid_t;
    typedef logic [`TIMESTAMP_W-1:0]  timestamp_t;
    typedef logic [`PKT_COUNT_W-1:0]  pkt_count_t;
    typedef logic [`ERR_COUNT_W-1:0]  err_count_t;
    typedef logic [2*`USB_BYTE_W-1:0] frame_num_t;   // SOF frame number, two bytes

    ////////////////////////////////////////////////////////////
    // Link side bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sop;
        logic  eop;
        pid_t  pid;
        logic  crc_valid;   // Meaningful on the EOP cycle
    } usb_rx_t;

    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sop;
        logic  eop;
        pid_t  pid;
    } usb_tx_t;

    // Decoder output, one cycle wide each
    typedef struct packed {
        logic host_start;
        logic dev_start;
        logic host_end;
        logic dev_end;
        logic crc_err;
        logic is_sof;
    } pkt_event_t;

    typedef struct packed {
        byte_t      data;
        byte_t      flags;       // PID in [7:4], direction in [0]
        timestamp_t timestamp;   // Taken at SOP
    } capture_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HOST_TO_DEV,
        ST_WAIT_DEV_RESP,
        ST_DEV_TO_HOST,
        ST_SOF
    } proxy_state_e;

endpackage

`default_nettype wire

// ==== hdl/usb_proxy_top.sv ====
/*
 * USB transparent proxy with capture tap
 * Packs the loose link ports into bundles and connects the
 * event decoder, proxy state machine and statistics block
 */
`default_nettype none

module usb_proxy_top (
    input  wire                            clk,
    input  wire                            rst_n,
    // Host side
    input  wire usb_proxy_pkg::byte_t      host_rx_data,
    input  wire                            host_rx_valid,
    input  wire                            host_rx_sop,
    input  wire                            host_rx_eop,
    input  wire usb_proxy_pkg::pid_t       host_rx_pid,
    input  wire                            host_rx_crc_valid,
    output usb_proxy_pkg::byte_t           host_tx_data,
    output logic                           host_tx_valid,
    output logic                           host_tx_sop,
    output logic                           host_tx_eop,
    output usb_proxy_pkg::pid_t            host_tx_pid,
    // Device side
    input  wire usb_proxy_pkg::byte_t      device_rx_data,
    input  wire                            device_rx_valid,
    input  wire                            device_rx_sop,
    input  wire                            device_rx_eop,
    input  wire usb_proxy_pkg::pid_t       device_rx_pid,
    input  wire                            device_rx_crc_valid,
    output usb_proxy_pkg::byte_t           device_tx_data,
    output logic                           device_tx_valid,
    output logic                           device_tx_sop,
    output logic                           device_tx_eop,
    output usb_proxy_pkg::pid_t            device_tx_pid,
    // Control, capture and readback
    input  wire usb_proxy_pkg::timestamp_t timestamp,
    input  wire [1:0]                      device_line_state,
    input  wire                            proxy_enable,
    input  wire                            buffer_ready,
    output usb_proxy_pkg::byte_t           capture_data,
    output usb_proxy_pkg::byte_t           capture_flags,
    output usb_proxy_pkg::timestamp_t      capture_timestamp,
    output logic                           capture_valid,
    input  wire usb_proxy_pkg::byte_t      reg_addr,
    output usb_proxy_pkg::byte_t           status_register,
    output usb_proxy_pkg::byte_t           reg_read_data
);

    import usb_proxy_pkg::*;

    usb_rx_t    host_rx;
    usb_rx_t    device_rx;
    usb_tx_t    host_tx;
    usb_tx_t    device_tx;
    pkt_event_t events;
    capture_t   capture;
    frame_num_t frame_num;
    logic       host_counted;
    logic       dev_counted;
    logic       drop;
    logic       connected;

    // Field order follows the struct definitions
    assign host_rx   = {host_rx_data, host_rx_valid, host_rx_sop, host_rx_eop,
                        host_rx_pid, host_rx_crc_valid};
    assign device_rx = {device_rx_data, device_rx_valid, device_rx_sop, device_rx_eop,
                        device_rx_pid, device_rx_crc_valid};
    assign {host_tx_data, host_tx_valid, host_tx_sop, host_tx_eop, host_tx_pid} = host_tx;
    assign {device_tx_data, device_tx_valid, device_tx_sop, device_tx_eop,
            device_tx_pid} = device_tx;
    assign {capture_data, capture_flags, capture_timestamp} = capture;

    pkt_decode i_decode (
        .host_rx   (host_rx),
        .device_rx (device_rx),
        .events    (events)
    );

    proxy_fsm i_fsm (
        .clk               (clk),
        .rst_n             (rst_n),
        .host_rx           (host_rx),
        .device_rx         (device_rx),
        .events            (events),
        .proxy_enable      (proxy_enable),
        .device_line_state (device_line_state),
        .timestamp         (timestamp),
        .buffer_ready      (buffer_ready),
        .host_tx           (host_tx),
        .device_tx         (device_tx),
        .capture           (capture),
        .capture_valid     (capture_valid),
        .host_counted      (host_counted),
        .dev_counted       (dev_counted),
        .drop              (drop),
        .frame_num         (frame_num),
        .connected         (connected)
    );

    monitor_stats i_stats (
        .clk             (clk),
        .rst_n           (rst_n),
        .events          (events),
        .host_counted    (host_counted),
        .dev_counted     (dev_counted),
        .drop            (drop),
        .frame_num       (frame_num),
        .connected       (connected),
        .proxy_enable    (proxy_enable),
        .reg_addr        (reg_addr),
        .status_register (status_register),
        .reg_read_data   (reg_read_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_usb_proxy.sv ====
/*
 * Testbench for the USB proxy
 * Plays a table of host and device packets through the DUT and
 * checks forwarding, capture, status and readback every clock
 * against a cycle model
 */
`default_nettype none

`include "usb_proxy_defines.svh"

module tb_usb_proxy;

    import usb_proxy_pkg::*;

    localparam int   clk_period = 100;
    localparam int   num_pkts   = 16;
    localparam pid_t pid_data0  = 4'b0011;

    typedef struct packed {
        logic        side;     // 0 host, 1 device
        pid_t        pid;
        logic [7:0]  len;
        logic        crc_ok;
        logic        en;
        logic        rnd_br;   // Random buffer_ready gaps
        logic [15:0] gap;      // Idle cycles before the packet
        logic        acc;      // Proxy takes the start
    } pkt_entry_t;

    // side, pid, len, crc_ok, en, rnd_br, gap, acc
    pkt_entry_t tbl [num_pkts] = '{
        '{1'b0, `PID_OUT,   8'd6,  1'b1, 1'b1, 1'b0, 16'd2, 1'b1},
        '{1'b1, `PID_ACK,   8'd1,  1'b1, 1'b1, 1'b0, 16'd3, 1'b1},   // Response to OUT
        '{1'b0, `PID_IN,    8'd3,  1'b1, 1'b1, 1'b1, 16'd2, 1'b1},
        '{1'b1, pid_data0,  8'd12, 1'b1, 1'b1, 1'b1, 16'd4, 1'b1},
        '{1'b0, `PID_SOF,   8'd3,  1'b1, 1'b1, 1'b0, 16'd2, 1'b1},
        '{1'b0, `PID_SETUP, 8'd4,  1'b0, 1'b1, 1'b0, 16'd2, 1'b1},   // Bad CRC
        '{1'b1, `PID_ACK,   8'd1,  1'b1, 1'b1, 1'b0, 16'd3, 1'b1},
        '{1'b0, `PID_OUT,   8'd5,  1'b1, 1'b0, 1'b0, 16'd2, 1'b0},   // Proxy disabled
        '{1'b1, `PID_ACK,   8'd1,  1'b1, 1'b0, 1'b0, 16'd2, 1'b0},
        '{1'b0, `PID_OUT,   8'd4,  1'b1, 1'b1, 1'b1, 16'd2, 1'b1},   // Device stays silent
        // SOP falls on the last cycle of the response wait
        '{1'b0, `PID_OUT,   8'd3,  1'b1, 1'b1, 1'b0, 16'(`RESP_TIMEOUT - 18), 1'b0},
        '{1'b0, `PID_OUT,   8'd3,  1'b1, 1'b1, 1'b0, 16'd2, 1'b1},
        '{1'b1, pid_data0,  8'd8,  1'b0, 1'b1, 1'b1, 16'd2, 1'b1},
        '{1'b0, `PID_IN,    8'd3,  1'b1, 1'b1, 1'b0, 16'd2, 1'b1},
        '{1'b1, `PID_ACK,   8'd1,  1'b1, 1'b1, 1'b0, 16'(`RESP_TIMEOUT), 1'b1},
        '{1'b0, `PID_SOF,   8'd5,  1'b1, 1'b1, 1'b0, 16'd2, 1'b1}
    };

    logic       clk;
    logic       rst_n;
    usb_rx_t    host_in;
    usb_rx_t    dev_in;
    timestamp_t timestamp;
    logic [1:0] device_line_state;
    logic       proxy_enable;
    logic       buffer_ready;
    byte_t      reg_addr;
    byte_t      host_tx_data;
    logic       host_tx_valid;
    logic       host_tx_sop;
    logic       host_tx_eop;
    pid_t       host_tx_pid;
    byte_t      device_tx_data;
    logic       device_tx_valid;
    logic       device_tx_sop;
    logic       device_tx_eop;
    pid_t       device_tx_pid;
    byte_t      capture_data;
    byte_t      capture_flags;
    timestamp_t capture_timestamp;
    logic       capture_valid;
    byte_t      status_register;
    byte_t      reg_read_data;

    // Reference model state
    logic       cur_en;
    byte_t      cur_addr;
    int         err_count;
    capture_t   exp_cap;
    logic       exp_cap_valid;
    timestamp_t pkt_ts;
    byte_t      exp_status;
    logic       drop_sticky;
    pkt_count_t host_cnt;
    pkt_count_t dev_cnt;
    err_count_t crc_cnt;
    err_count_t drop_cnt;
    frame_num_t frame;

    usb_proxy_top i_dut (
        .clk (clk), .rst_n (rst_n),
        .host_rx_data (host_in.data), .host_rx_valid (host_in.valid),
        .host_rx_sop (host_in.sop), .host_rx_eop (host_in.eop),
        .host_rx_pid (host_in.pid), .host_rx_crc_valid (host_in.crc_valid),
        .host_tx_data (host_tx_data), .host_tx_valid (host_tx_valid),
        .host_tx_sop (host_tx_sop), .host_tx_eop (host_tx_eop), .host_tx_pid (host_tx_pid),
        .device_rx_data (dev_in.data), .device_rx_valid (dev_in.valid),
        .device_rx_sop (dev_in.sop), .device_rx_eop (dev_in.eop),
        .device_rx_pid (dev_in.pid), .device_rx_crc_valid (dev_in.crc_valid),
        .device_tx_data (device_tx_data), .device_tx_valid (device_tx_valid),
        .device_tx_sop (device_tx_sop), .device_tx_eop (device_tx_eop),
        .device_tx_pid (device_tx_pid),
        .timestamp (timestamp), .device_line_state (device_line_state),
        .proxy_enable (proxy_enable), .buffer_ready (buffer_ready),
        .capture_data (capture_data), .capture_flags (capture_flags),
        .capture_timestamp (capture_timestamp), .capture_valid (capture_valid),
        .reg_addr (reg_addr), .status_register (status_register),
        .reg_read_data (reg_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Register map as seen from the readback port
    function automatic byte_t expected_reg(input byte_t addr);
        if (addr == `REG_STATUS)
            return exp_status;
        if (addr == `REG_ERR_LO || addr == `REG_ERR_LO + 8'd1)
            return byte_t'(crc_cnt >> (8 * (addr - `REG_ERR_LO)));
        if (addr >= `REG_HOST_PKT0 && addr < `REG_HOST_PKT0 + 8'd4)
            return byte_t'(host_cnt >> (8 * (addr - `REG_HOST_PKT0)));
        if (addr >= `REG_DEV_PKT0 && addr < `REG_DEV_PKT0 + 8'd4)
            return byte_t'(dev_cnt >> (8 * (addr - `REG_DEV_PKT0)));
        if (addr == `REG_FRAME_LO || addr == `REG_FRAME_HI)
            return byte_t'(frame >> (8 * (addr - `REG_FRAME_LO)));
        if (addr == `REG_DROP_LO || addr == `REG_DROP_HI)
            return byte_t'(drop_cnt >> (8 * (addr - `REG_DROP_LO)));
        return '0;   // Unmapped
    endfunction

    ////////////////////////////////////////////////////////////
    // One clock: drive, check, advance the model
    ////////////////////////////////////////////////////////////

    task automatic run_cycle(input usb_rx_t h, input usb_rx_t d, input logic br,
                             input logic acc);
        logic        fwd;
        logic        byte_fwd;
        logic        drop_now;
        logic        crc_now;
        logic [14:0] exp_htx;
        logic [14:0] exp_dtx;
        @(negedge clk);
        host_in      = h;
        dev_in       = d;
        buffer_ready = br;
        proxy_enable = cur_en;
        reg_addr     = cur_addr;
        timestamp    = {$urandom, $urandom};
        #(clk_period / 4);

        fwd     = acc && !(h.valid && h.pid == `PID_SOF);   // SOF is consumed
        exp_htx = '0;
        exp_dtx = '0;
        if (fwd && h.valid)
            exp_dtx = {h.data, h.valid, h.sop, h.eop, h.pid};
        if (fwd && d.valid)
            exp_htx = {d.data, d.valid, d.sop, d.eop, d.pid};
        check_value("host_tx", {host_tx_data, host_tx_valid, host_tx_sop, host_tx_eop,
                    host_tx_pid}, exp_htx);
        check_value("device_tx", {device_tx_data, device_tx_valid, device_tx_sop,
                    device_tx_eop, device_tx_pid}, exp_dtx);
        check_value("capture_valid", capture_valid, exp_cap_valid);
        if (exp_cap_valid) begin
            check_value("capture_data", capture_data, exp_cap.data);
            check_value("capture_flags", capture_flags, exp_cap.flags);
            check_value("capture_timestamp", capture_timestamp, exp_cap.timestamp);
        end
        check_value("status_register", status_register, exp_status);
        check_value("reg_read_data", reg_read_data, expected_reg(cur_addr));

        byte_fwd = fwd && (h.valid || d.valid);
        drop_now = byte_fwd && !br;
        crc_now  = (h.valid && h.eop && !h.crc_valid) || (d.valid && d.eop && !d.crc_valid);
        if (fwd && (h.sop || d.sop))
            pkt_ts = timestamp;
        exp_cap_valid = byte_fwd && br;
        if (exp_cap_valid) begin
            exp_cap.data      = h.valid ? h.data : d.data;
            exp_cap.flags     = {(h.valid ? h.pid : d.pid), 3'b000, d.valid};
            exp_cap.timestamp = pkt_ts;
        end
        if (acc && h.sop)
            host_cnt = host_cnt + 1'b1;
        if (acc && d.sop)
            dev_cnt = dev_cnt + 1'b1;
        if (crc_now)
            crc_cnt = crc_cnt + 1'b1;
        if (drop_now)
            drop_cnt = drop_cnt + 1'b1;
        drop_sticky                 = drop_sticky || drop_now;
        exp_status                  = '0;
        exp_status[`STAT_CONNECTED] = 1'b1;   // Line state held non-zero
        exp_status[`STAT_ERROR]     = crc_now;
        exp_status[`STAT_PROXY_EN]  = cur_en;
        exp_status[`STAT_DROP]      = drop_sticky;
    endtask

    task automatic send_packet(input pkt_entry_t e);
        usb_rx_t idle;
        usb_rx_t cur;
        logic    br;
        idle   = '0;
        cur_en = e.en;
        repeat (e.gap) run_cycle(idle, idle, 1'b1, 1'b0);
        for (int i = 0; i < e.len; i++) begin
            cur           = '0;
            cur.data      = byte_t'($urandom);
            cur.valid     = 1'b1;
            cur.sop       = (i == 0);
            cur.eop       = (i == e.len - 1);
            cur.pid       = e.pid;
            cur.crc_valid = e.crc_ok;
            br = e.rnd_br ? ((i != 1) && ($urandom % 4 != 0)) : 1'b1;   // Byte 1 always lost
            if (e.side)
                run_cycle(idle, cur, br, e.acc);
            else
                run_cycle(cur, idle, br, e.acc);
            if (e.acc && !e.side && e.pid == `PID_SOF && i == 1)
                frame[7:0] = cur.data;
            if (e.acc && !e.side && e.pid == `PID_SOF && i == 2)
                frame[15:8] = cur.data;
        end
        run_cycle(idle, idle, 1'b1, 1'b0);   // Last capture, strobes back to 0
    endtask

    task automatic sweep_regs();
        usb_rx_t idle;
        idle = '0;
        for (int a = 0; a < 16; a++) begin
            cur_addr = byte_t'(a);
            run_cycle(idle, idle, 1'b1, 1'b0);
        end
        cur_addr = `REG_STATUS;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hbac329eb));
        rst_n = 1'b0;
        host_in = '0;
        dev_in = '0;
        timestamp = '0;
        device_line_state = 2'b01;
        proxy_enable = 1'b1;
        buffer_ready = 1'b1;
        reg_addr = `REG_STATUS;
        cur_en = 1'b1;
        cur_addr = `REG_STATUS;
        err_count = 0;
        exp_cap = '0;
        exp_cap_valid = 1'b0;
        pkt_ts = '0;
        drop_sticky = 1'b0;
        host_cnt = '0;
        dev_cnt = '0;
        crc_cnt = '0;
        drop_cnt = '0;
        frame = '0;
        exp_status = 8'h05;   // Connected and enabled once out of reset
        repeat (5) @(negedge clk);
        check_value("status_register", status_register, 8'h00);
        check_value("capture_valid", capture_valid, 1'b0);
        check_value("tx_valid", {host_tx_valid, device_tx_valid}, 2'b00);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        for (int p = 0; p < num_pkts; p++) begin
            send_packet(tbl[p]);
            sweep_regs();
        end

        if (err_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        int budget;
        budget = 0;
        for (int p = 0; p < num_pkts; p++)
            budget += tbl[p].len;
        budget = budget * `RESP_TIMEOUT + 1000;
        repeat (budget) @(posedge clk);
        $display("Simulation timed out after %0d clock cycles", budget);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
